//--- list.f
src/dcache_pkg.sv
src/dcache_lru.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/mem_responder.sv
sim/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - src/dcache_pkg.sv
      - src/dcache_lru.sv
      - src/dcache_tag_array.sv
      - src/dcache_data_array.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: simulation
    files:
      - sim/mem_responder.sv
      - sim/tb_dcache.sv

//--- sim/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int num_sets     = 64;
    localparam int index_width  = $clog2(num_sets);
    localparam int offset_width = $clog2(dcache_pkg::words_per_line * dcache_pkg::bytes_per_word);
    localparam int tag_width    = dcache_pkg::data_width - index_width - offset_width;
    localparam int n_loads      = 40;
    localparam int n_mixed      = 200;
    localparam int n_ops        = 1 + n_loads + n_mixed + 6 + 4;
    localparam int op_bound     = 80;   // cycles, miss with write-back and longest delays
    localparam int watchdog_ns  = (n_ops * op_bound + 16) * 8;

    logic                       clk;
    logic                       reset;
    logic                       req_valid;
    logic                       req_write;
    logic [index_width-1:0]     req_index;
    logic [tag_width-1:0]       req_tag;
    logic [offset_width-1:0]    req_offset;
    logic [31:0]                req_wdata;
    logic [3:0]                 req_wstrb;
    logic [31:0]                rdata;
    logic                       busy;
    logic                       rd_req;
    logic [31:0]                rd_addr;
    logic                       rd_rdy;
    logic                       ret_valid;
    logic [127:0]               ret_data;
    logic                       wr_req;
    logic [31:0]                wr_addr;
    logic [127:0]               wr_data;
    logic                       wr_rdy;
    logic                       wr_done;
    logic [2:0]                 rdy_delay;
    logic [2:0]                 ret_delay;

    dcache_top #(
        .num_sets (num_sets)
    ) dcache_top_inst (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req_write (req_write), .req_index (req_index),
        .req_tag (req_tag), .req_offset (req_offset), .req_wdata (req_wdata),
        .req_wstrb (req_wstrb), .rdata (rdata), .busy (busy),
        .rd_req (rd_req), .rd_addr (rd_addr), .rd_rdy (rd_rdy),
        .ret_valid (ret_valid), .ret_data (ret_data),
        .wr_req (wr_req), .wr_addr (wr_addr), .wr_data (wr_data),
        .wr_rdy (wr_rdy), .wr_done (wr_done)
    );

    mem_responder mem_responder_inst (
        .clk (clk), .reset (reset),
        .rd_req (rd_req), .rd_addr (rd_addr), .rd_rdy (rd_rdy),
        .ret_valid (ret_valid), .ret_data (ret_data),
        .wr_req (wr_req), .wr_addr (wr_addr), .wr_data (wr_data),
        .wr_rdy (wr_rdy), .wr_done (wr_done),
        .rdy_delay (rdy_delay), .ret_delay (ret_delay)
    );

    // reference model
    logic [31:0]            m_mem [int unsigned];
    logic [tag_width-1:0]   m_tag [num_sets][2];
    bit                     m_valid [num_sets][2];
    bit                     m_dirty [num_sets][2];
    bit                     m_lru [num_sets];      // way not used most recently

    // line transfers seen and expected, kind 0 is a write-back, 1 a refill read
    int             ev_kind[$];
    logic [31:0]    ev_addr[$];
    logic [127:0]   ev_data[$];
    int             exp_kind[$];
    logic [31:0]    exp_addr[$];
    logic [127:0]   exp_data[$];

    logic [31:0]    lfsr_state = 32'd5;
    int             test_checks, test_errors;
    int             tests_run, tests_failed, total_checks, total_errors;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired, the cache stopped responding");
        $display("RESULT: FAIL");
        $finish;
    end

    always @(posedge clk) begin
        if (wr_req && wr_rdy) begin
            ev_kind.push_back(0);
            ev_addr.push_back(wr_addr);
            ev_data.push_back(wr_data);
        end
        if (rd_req && rd_rdy) begin
            ev_kind.push_back(1);
            ev_addr.push_back(rd_addr);
            ev_data.push_back('0);
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] model_word(input int unsigned waddr);
        if (m_mem.exists(waddr))
            return m_mem[waddr];
        return {waddr[13:0], waddr[29:12]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [127:0] model_line(input logic [31:0] addr);
        logic [127:0] l;
        for (int k = 0; k < 4; k++)
            l[k*32 +: 32] = model_word(addr[31:2] + k);
        return l;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("ERROR %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic do_op(input logic wr, input logic [tag_width-1:0] tag,
                         input logic [index_width-1:0] idx, input logic [1:0] word,
                         input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [31:0] addr;
        logic [31:0] line_addr;
        logic [31:0] exp_word;
        int          way;
        int          n;
        addr = {tag, idx, word, 2'b00};
        exp_kind.delete();
        exp_addr.delete();
        exp_data.delete();
        way = -1;
        for (int w = 0; w < 2; w++)
            if (m_valid[idx][w] && m_tag[idx][w] == tag)
                way = w;
        if (way < 0) begin
            way = m_lru[idx];
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                line_addr = {m_tag[idx][way], idx, 4'b0000};
                exp_kind.push_back(0);
                exp_addr.push_back(line_addr);
                exp_data.push_back(model_line(line_addr));
            end
            exp_kind.push_back(1);
            exp_addr.push_back({tag, idx, 4'b0000});
            exp_data.push_back('0);
            m_tag[idx][way]   = tag;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
        end
        m_lru[idx] = (way == 0);
        if (wr)
            m_dirty[idx][way] = 1'b1;
        exp_word = model_word(addr[31:2]);

        ev_kind.delete();
        ev_addr.delete();
        ev_data.delete();
        @(posedge clk);
        req_valid  <= 1'b1;
        req_write  <= wr;
        req_tag    <= tag;
        req_index  <= idx;
        req_offset <= {word, 2'b00};
        req_wdata  <= wdata;
        req_wstrb  <= wstrb;
        rdy_delay  <= 3'(rand_bits(3));
        ret_delay  <= 3'(rand_bits(3));
        @(negedge clk);
        while (busy)
            @(negedge clk);
        @(posedge clk);     // accepted here
        req_valid <= 1'b0;
        @(negedge clk);
        while (busy)
            @(negedge clk);

        if (!wr) begin
            check("rdata", rdata, exp_word);
        end else begin
            for (int b = 0; b < 4; b++)
                if (wstrb[b])
                    exp_word[b*8 +: 8] = wdata[b*8 +: 8];
            m_mem[addr[31:2]] = exp_word;
        end
        check("line transfer count", ev_kind.size(), exp_kind.size());
        n = (ev_kind.size() < exp_kind.size()) ? ev_kind.size() : exp_kind.size();
        for (int i = 0; i < n; i++) begin
            check("transfer kind", ev_kind[i], exp_kind[i]);
            check(exp_kind[i] == 0 ? "wr_addr" : "rd_addr", ev_addr[i], exp_addr[i]);
            if (exp_kind[i] == 0)
                check("wr_data", ev_data[i], exp_data[i]);
        end
    endtask

    task automatic random_op(input bit allow_store);
        logic                   wr;
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] idx;
        logic [1:0]             word;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        wr    = allow_store ? rand_bits(1) : 1'b0;
        tag   = tag_width'(32'h35 + rand_bits(2) * 32'h1c1);   // small pool, many conflicts
        idx   = index_width'(rand_bits(2) * 7);
        word  = 2'(rand_bits(2));
        wdata = rand_bits(32);
        wstrb = 4'(rand_bits(4));
        do_op(wr, tag, idx, word, wdata, wstrb);
    endtask

    initial begin
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_index  = '0;
        req_tag    = '0;
        req_offset = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        rdy_delay  = '0;
        ret_delay  = '0;
        reset      = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        check("busy", busy, 1'b0);
        check("rd_req", rd_req, 1'b0);
        check("wr_req", wr_req, 1'b0);
        do_op(1'b0, 'h2a5, 'd3, 2'd2, '0, '0);
        finish_test("reset_first_load");

        repeat (n_loads) random_op(1'b0);
        finish_test("random_loads");

        repeat (n_mixed) random_op(1'b1);
        finish_test("random_stores");

        // clean victim first, then a dirty one
        do_op(1'b0, 'h101, 'd9, 2'd0, '0, '0);
        do_op(1'b0, 'h102, 'd9, 2'd1, '0, '0);
        do_op(1'b0, 'h103, 'd9, 2'd2, '0, '0);
        do_op(1'b1, 'h103, 'd9, 2'd3, 32'hdead_beef, 4'b0110);
        do_op(1'b1, 'h102, 'd9, 2'd0, 32'h1234_5678, 4'b1111);
        do_op(1'b0, 'h101, 'd9, 2'd1, '0, '0);
        finish_test("victim_write_back");

        // b touched before a, so b is evicted
        do_op(1'b1, 'h201, 'd17, 2'd0, 32'haaaa_5555, 4'b1001);
        do_op(1'b1, 'h202, 'd17, 2'd1, 32'h0f0f_f0f0, 4'b0011);
        do_op(1'b0, 'h201, 'd17, 2'd2, '0, '0);
        do_op(1'b0, 'h203, 'd17, 2'd3, '0, '0);
        finish_test("lru_order");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim/mem_responder.sv
`timescale 1ns/1ps

module mem_responder (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rd_req,
    input  logic [dcache_pkg::data_width-1:0]   rd_addr,
    output logic                                rd_rdy,
    output logic                                ret_valid,
    output logic [dcache_pkg::line_width-1:0]   ret_data,
    input  logic                                wr_req,
    input  logic [dcache_pkg::data_width-1:0]   wr_addr,
    input  logic [dcache_pkg::line_width-1:0]   wr_data,
    output logic                                wr_rdy,
    output logic                                wr_done,
    input  logic [2:0]                          rdy_delay,  // edges before ready
    input  logic [2:0]                          ret_delay   // edges before done or return
);

    localparam int dw = dcache_pkg::data_width;

    logic [dw-1:0] mem [int unsigned];  // keyed by word address

    // untouched words follow a pattern of the whole address
    function automatic logic [dw-1:0] word_at(input int unsigned waddr);
        if (mem.exists(waddr))
            return mem[waddr];
        return {waddr[13:0], waddr[29:12]} ^ 32'h3c5a_96e1;
    endfunction

    initial begin
        logic [dcache_pkg::line_width-1:0] line;
        int unsigned                       base;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_done   = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset && wr_req) begin
                repeat (rdy_delay) @(posedge clk);
                wr_rdy <= 1'b1;
                @(posedge clk);
                wr_rdy <= 1'b0;
                base = wr_addr[dw-1:2];
                for (int k = 0; k < dcache_pkg::words_per_line; k++)
                    mem[base + k] = wr_data[k*dw +: dw];
                repeat (ret_delay) @(posedge clk);
                wr_done <= 1'b1;
                @(posedge clk);
                wr_done <= 1'b0;
            end else if (!reset && rd_req) begin
                repeat (rdy_delay) @(posedge clk);
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                base = rd_addr[dw-1:2];     // address held until this edge
                for (int k = 0; k < dcache_pkg::words_per_line; k++)
                    line[k*dw +: dw] = word_at(base + k);
                repeat (ret_delay) @(posedge clk);
                ret_data  <= line;
                ret_valid <= 1'b1;
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int num_sets = 256,
    localparam int index_width  = $clog2(num_sets),
    localparam int offset_width = $clog2(dcache_pkg::words_per_line * dcache_pkg::bytes_per_word),
    localparam int tag_width    = dcache_pkg::data_width - index_width - offset_width
) (
    input  logic                                clk,
    input  logic                                reset,
    // processor side
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [index_width-1:0]              req_index,
    input  logic [tag_width-1:0]                req_tag,
    input  logic [offset_width-1:0]             req_offset,
    input  logic [dcache_pkg::data_width-1:0]   req_wdata,
    input  logic [dcache_pkg::bytes_per_word-1:0] req_wstrb,
    output logic [dcache_pkg::data_width-1:0]   rdata,
    output logic                                busy,
    // line memory side
    output logic                                rd_req,
    output logic [dcache_pkg::data_width-1:0]   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic [dcache_pkg::line_width-1:0]   ret_data,
    output logic                                wr_req,
    output logic [dcache_pkg::data_width-1:0]   wr_addr,
    output logic [dcache_pkg::line_width-1:0]   wr_data,
    input  logic                                wr_rdy,
    input  logic                                wr_done
);

    logic [index_width-1:0]                 lookup_index;
    logic [index_width-1:0]                 buf_index;
    logic [offset_width-1:0]                buf_offset;
    logic [dcache_pkg::bytes_per_word-1:0]  buf_wstrb;
    logic [dcache_pkg::data_width-1:0]      buf_wdata;
    logic [dcache_pkg::way_width-1:0]       sel_way;
    logic [dcache_pkg::way_width-1:0]       lru_way;
    logic [dcache_pkg::way_width-1:0]       victim_way;
    logic [dcache_pkg::num_ways-1:0]        hit_way;
    logic [dcache_pkg::num_ways-1:0]        way_dirty;
    logic [tag_width-1:0]                   victim_tag;
    logic                                   fill_en;
    logic                                   store_en;
    logic                                   set_dirty;
    logic                                   lru_touch;

    dcache_ctrl #(
        .num_sets (num_sets)
    ) dcache_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .req_offset   (req_offset),
        .req_wdata    (req_wdata),
        .req_wstrb    (req_wstrb),
        .hit_way      (hit_way),
        .way_dirty    (way_dirty),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .wr_rdy       (wr_rdy),
        .wr_done      (wr_done),
        .busy         (busy),
        .lookup_index (lookup_index),
        .buf_index    (buf_index),
        .buf_offset   (buf_offset),
        .buf_wstrb    (buf_wstrb),
        .buf_wdata    (buf_wdata),
        .sel_way      (sel_way),
        .fill_en      (fill_en),
        .store_en     (store_en),
        .set_dirty    (set_dirty),
        .lru_touch    (lru_touch),
        .lru_way      (lru_way),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr)
    );

    // buffered tag is the top field of the line address
    dcache_tag_array #(
        .num_sets (num_sets)
    ) dcache_tag_array_inst (
        .clk            (clk),
        .reset          (reset),
        .lookup_index   (lookup_index),
        .lookup_tag     (rd_addr[dcache_pkg::data_width-1 -: tag_width]),
        .buf_index      (buf_index),
        .fill_en        (fill_en),
        .fill_way       (sel_way),
        .set_dirty      (set_dirty),
        .dirty_way      (sel_way),
        .hit_way        (hit_way),
        .way_dirty      (way_dirty),
        .victim_tag_out (victim_tag)
    );

    dcache_data_array #(
        .num_sets (num_sets)
    ) dcache_data_array_inst (
        .clk         (clk),
        .read_index  (lookup_index),
        .buf_index   (buf_index),
        .buf_offset  (buf_offset),
        .sel_way     (sel_way),
        .fill_en     (fill_en),
        .fill_way    (sel_way),
        .ret_data    (ret_data),
        .store_en    (store_en),
        .buf_wstrb   (buf_wstrb),
        .buf_wdata   (buf_wdata),
        .rdata       (rdata),
        .victim_line (wr_data)
    );

    dcache_lru #(
        .num_sets (num_sets)
    ) dcache_lru_inst (
        .clk        (clk),
        .reset      (reset),
        .lru_touch  (lru_touch),
        .buf_index  (buf_index),
        .lru_way    (lru_way),
        .victim_way (victim_way)
    );

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int num_sets = 256,
    localparam int index_width  = $clog2(num_sets),
    localparam int offset_width = $clog2(dcache_pkg::words_per_line * dcache_pkg::bytes_per_word),
    localparam int tag_width    = dcache_pkg::data_width - index_width - offset_width
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req_valid,
    input  logic                                  req_write,
    input  logic [index_width-1:0]                req_index,
    input  logic [tag_width-1:0]                  req_tag,
    input  logic [offset_width-1:0]               req_offset,
    input  logic [dcache_pkg::data_width-1:0]     req_wdata,
    input  logic [dcache_pkg::bytes_per_word-1:0] req_wstrb,
    input  logic [dcache_pkg::num_ways-1:0]       hit_way,
    input  logic [dcache_pkg::num_ways-1:0]       way_dirty,
    input  logic [dcache_pkg::way_width-1:0]      victim_way,
    input  logic [tag_width-1:0]                  victim_tag,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    input  logic                                  wr_rdy,
    input  logic                                  wr_done,
    output logic                                  busy,
    output logic [index_width-1:0]                lookup_index,
    output logic [index_width-1:0]                buf_index,
    output logic [offset_width-1:0]               buf_offset,
    output logic [dcache_pkg::bytes_per_word-1:0] buf_wstrb,
    output logic [dcache_pkg::data_width-1:0]     buf_wdata,
    output logic [dcache_pkg::way_width-1:0]      sel_way,
    output logic                                  fill_en,
    output logic                                  store_en,
    output logic                                  set_dirty,
    output logic                                  lru_touch,
    output logic [dcache_pkg::way_width-1:0]      lru_way,
    output logic                                  rd_req,
    output logic [dcache_pkg::data_width-1:0]     rd_addr,
    output logic                                  wr_req,
    output logic [dcache_pkg::data_width-1:0]     wr_addr
);

    dcache_pkg::cache_state_t state;
    dcache_pkg::cache_state_t state_next;

    logic                               pend;       // buffered request still needs its lookup
    logic                               buf_write;
    logic [tag_width-1:0]               buf_tag;
    logic                               st_q;       // write buffer holds a store
    logic [dcache_pkg::way_width-1:0]   st_way;
    logic                               accept;
    logic                               hit;
    logic                               done_hit;
    logic [dcache_pkg::way_width-1:0]   hit_idx;

    assign hit      = |hit_way;
    assign hit_idx  = hit_way[1];   // two ways only
    assign done_hit = (state == dcache_pkg::lookup) && pend && hit;

    // a store hit costs one extra cycle for the merge
    assign busy   = (state != dcache_pkg::lookup) || (pend && (!hit || buf_write));
    assign accept = req_valid && !busy;

    // keep re-reading the buffered set while waiting
    assign lookup_index = accept ? req_index : buf_index;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_write  <= req_write;
            buf_index  <= req_index;
            buf_tag    <= req_tag;
            buf_offset <= req_offset;
            buf_wdata  <= req_wdata;
            buf_wstrb  <= req_wstrb;
        end
        if (done_hit)
            st_way <= hit_idx;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend  <= 1'b0;
            st_q  <= 1'b0;
            state <= dcache_pkg::lookup;
        end else begin
            pend  <= accept || (pend && !done_hit);
            st_q  <= done_hit && buf_write;
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::lookup:
                if (pend && !hit)
                    state_next = way_dirty[victim_way] ? dcache_pkg::miss_dirty
                                                       : dcache_pkg::miss_clean;
            dcache_pkg::miss_dirty:
                if (wr_rdy)
                    state_next = dcache_pkg::write_back;
            dcache_pkg::write_back:
                if (wr_done)
                    state_next = dcache_pkg::miss_clean;
            dcache_pkg::miss_clean:
                if (rd_rdy)
                    state_next = dcache_pkg::refill;
            dcache_pkg::refill:
                if (ret_valid)
                    state_next = dcache_pkg::refill_done;
            default:
                state_next = dcache_pkg::lookup;
        endcase
    end

    always_comb begin
        if (st_q)
            sel_way = st_way;
        else if (state == dcache_pkg::lookup && hit)
            sel_way = hit_idx;
        else
            sel_way = victim_way;
    end

    assign fill_en   = (state == dcache_pkg::refill) && ret_valid;
    assign store_en  = st_q;
    assign set_dirty = done_hit && buf_write;
    assign lru_touch = done_hit || fill_en;
    assign lru_way   = sel_way;

    assign rd_req  = (state == dcache_pkg::miss_clean);
    assign wr_req  = (state == dcache_pkg::miss_dirty);
    assign rd_addr = {buf_tag, buf_index, {offset_width{1'b0}}};
    assign wr_addr = {victim_tag, buf_index, {offset_width{1'b0}}};

    assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req));

    assert property (@(posedge clk) disable iff (reset) state != dcache_pkg::lookup |-> busy);

endmodule

//--- src/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int num_sets = 256,
    localparam int index_width  = $clog2(num_sets),
    localparam int offset_width = $clog2(dcache_pkg::words_per_line * dcache_pkg::bytes_per_word),
    localparam int byte_bits    = $clog2(dcache_pkg::bytes_per_word)
) (
    input  logic                                  clk,
    input  logic [index_width-1:0]                read_index,
    input  logic [index_width-1:0]                buf_index,
    input  logic [offset_width-1:0]               buf_offset,
    input  logic [dcache_pkg::way_width-1:0]      sel_way,
    input  logic                                  fill_en,
    input  logic [dcache_pkg::way_width-1:0]      fill_way,
    input  logic [dcache_pkg::line_width-1:0]     ret_data,
    input  logic                                  store_en,
    input  logic [dcache_pkg::bytes_per_word-1:0] buf_wstrb,
    input  logic [dcache_pkg::data_width-1:0]     buf_wdata,
    output logic [dcache_pkg::data_width-1:0]     rdata,
    output logic [dcache_pkg::line_width-1:0]     victim_line
);

    localparam int dw = dcache_pkg::data_width;

    wire  [dw-1:0]                      rd_word [dcache_pkg::num_ways][dcache_pkg::words_per_line];
    logic [offset_width-byte_bits-1:0]  word_sel;
    logic [dw-1:0]                      merged;

    assign word_sel = buf_offset[offset_width-1:byte_bits];
    assign rdata    = rd_word[sel_way][word_sel];

    // strobed bytes over the word read in the lookup
    always_comb begin
        merged = rdata;
        for (int b = 0; b < dcache_pkg::bytes_per_word; b++) begin
            if (buf_wstrb[b])
                merged[b*dcache_pkg::byte_width +: dcache_pkg::byte_width] =
                    buf_wdata[b*dcache_pkg::byte_width +: dcache_pkg::byte_width];
        end
    end

    for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_way
        for (genvar k = 0; k < dcache_pkg::words_per_line; k++) begin : g_word
            logic [dw-1:0] mem [num_sets];
            logic [dw-1:0] rd_q;
            logic [dw-1:0] wdata;
            logic          we;

            assign we    = (fill_en && fill_way == w) ||
                           (store_en && sel_way == w && word_sel == k);
            assign wdata = fill_en ? ret_data[k*dw +: dw] : merged;

            always_ff @(posedge clk) begin
                if (we)
                    mem[buf_index] <= wdata;
                if (we && buf_index == read_index)
                    rd_q <= wdata;      // write-first, a store may be followed by a load
                else
                    rd_q <= mem[read_index];
            end

            assign rd_word[w][k] = rd_q;
        end
    end

    for (genvar k = 0; k < dcache_pkg::words_per_line; k++) begin : g_victim
        assign victim_line[k*dw +: dw] = rd_word[fill_way][k];
    end

endmodule

//--- src/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array #(
    parameter int num_sets = 256,
    localparam int index_width  = $clog2(num_sets),
    localparam int offset_width = $clog2(dcache_pkg::words_per_line * dcache_pkg::bytes_per_word),
    localparam int tag_width    = dcache_pkg::data_width - index_width - offset_width
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [index_width-1:0]           lookup_index,
    input  logic [tag_width-1:0]             lookup_tag,
    input  logic [index_width-1:0]           buf_index,
    input  logic                             fill_en,
    input  logic [dcache_pkg::way_width-1:0] fill_way,
    input  logic                             set_dirty,
    input  logic [dcache_pkg::way_width-1:0] dirty_way,
    output logic [dcache_pkg::num_ways-1:0]  hit_way,
    output logic [dcache_pkg::num_ways-1:0]  way_dirty,
    output logic [tag_width-1:0]             victim_tag_out
);

    logic [tag_width-1:0]                           tag_mem [dcache_pkg::num_ways][num_sets];
    logic [dcache_pkg::num_ways-1:0][num_sets-1:0]  valid_q;
    logic [dcache_pkg::num_ways-1:0][num_sets-1:0]  dirty_q;
    logic [tag_width-1:0]                           tag_rd [dcache_pkg::num_ways];
    logic [dcache_pkg::num_ways-1:0]                valid_rd;
    logic [dcache_pkg::num_ways-1:0]                dirty_rd;

    always_ff @(posedge clk) begin
        if (fill_en)
            tag_mem[fill_way][buf_index] <= lookup_tag;
        for (int w = 0; w < dcache_pkg::num_ways; w++)
            tag_rd[w] <= tag_mem[w][lookup_index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            valid_rd <= '0;
            dirty_rd <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_way][buf_index] <= 1'b1;
                dirty_q[fill_way][buf_index] <= 1'b0;   // fresh line is clean
            end else if (set_dirty) begin
                dirty_q[dirty_way][buf_index] <= 1'b1;
            end
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
                valid_rd[w] <= valid_q[w][lookup_index];
                dirty_rd[w] <= dirty_q[w][lookup_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++)
            hit_way[w] = valid_rd[w] && (tag_rd[w] == lookup_tag);
    end

    assign way_dirty      = dirty_rd;
    assign victim_tag_out = tag_rd[fill_way];

    // a refill only happens on a miss, so a tag never lives in both ways
    assert property (@(posedge clk) disable iff (reset) $onehot0(hit_way));

endmodule

//--- src/dcache_lru.sv
`timescale 1ns/1ps

module dcache_lru #(
    parameter int num_sets = 256,
    localparam int index_width = $clog2(num_sets)
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             lru_touch,
    input  logic [index_width-1:0]           buf_index,
    input  logic [dcache_pkg::way_width-1:0] lru_way,
    output logic [dcache_pkg::way_width-1:0] victim_way
);

    // bit set = way 1 is the older one
    logic [num_sets-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (reset)
            lru_q <= '0;
        else if (lru_touch)
            lru_q[buf_index] <= ~lru_way;   // point at the other way
    end

    assign victim_way = lru_q[buf_index];

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

    // processor word and line geometry
    localparam int data_width     = 32;
    localparam int words_per_line = 4;
    localparam int bytes_per_word = 4;    // also the strobe width
    localparam int byte_width     = 8;
    localparam int line_width     = data_width * words_per_line;

    // associativity is fixed, the way logic only handles two
    localparam int num_ways  = 2;
    localparam int way_width = $clog2(num_ways);

    // miss controller states
    typedef enum logic [2:0] {
        lookup,
        miss_dirty,     // waiting for wr_rdy
        write_back,     // waiting for wr_done
        miss_clean,     // waiting for rd_rdy
        refill,         // waiting for ret_valid
        refill_done
    } cache_state_t;

endpackage
